//--- common/scb_config.svh
`ifndef SCB_CONFIG_SVH
`define SCB_CONFIG_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

`define SCB_DATA_W 16
`define SCB_INSTR_W 16

//////////////////////////////////////////////////
// architectural state
//////////////////////////////////////////////////

`define SCB_NUM_REGS 8
`define SCB_REG_AW 3

// arithmetic units and their pipeline depth (1 to 3)
`define SCB_NUM_FU 2
`define SCB_ALU_STAGES 2

`endif

//--- common/scb_pkg.sv
`include "scb_config.svh"

package scb_pkg;

	// instruction opcode field, bits 15..11
	typedef enum logic [4:0] {
		OPC_ADD_IMM = 5'b00000,
		OPC_ADD_REG = 5'b00001,
		OPC_SUB_IMM = 5'b00010,
		OPC_SUB_REG = 5'b00011
	} opcode_e;

	typedef enum logic {
		ALU_ADD = 1'b0,
		ALU_SUB = 1'b1
	} alu_op_e;

	// four-phase receiver
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACK,
		HS_WAIT_LOW
	} hs_state_e;

	typedef logic [`SCB_REG_AW-1:0] reg_addr_t;
	typedef logic [`SCB_DATA_W-1:0] data_t;
	typedef logic [$clog2(`SCB_NUM_FU)-1:0] fu_tag_t;

endpackage

//--- common/scb_if.sv
`timescale 1ns/1ps

// decoded instruction, intake to scoreboard
interface dec_if;
	import scb_pkg::*;
	logic valid;
	logic take;
	alu_op_e op;
	reg_addr_t dest;
	reg_addr_t src0;
	reg_addr_t src1;
	logic use_imm;
	data_t imm;
	modport source (output valid, op, dest, src0, src1, use_imm, imm, input take);
	modport sink (input valid, op, dest, src0, src1, use_imm, imm, output take);
endinterface

// dispatch and writeback of one arithmetic unit
interface fu_if;
	import scb_pkg::*;
	logic start;
	alu_op_e op;
	reg_addr_t dest;
	data_t a;
	data_t b;
	logic wb_valid;
	reg_addr_t wb_dest;
	data_t wb_value;
	modport issue (output start, op, dest, a, b, input wb_valid, wb_dest, wb_value);
	modport unit (input start, op, dest, a, b, output wb_valid, wb_dest, wb_value);
	modport monitor (input wb_valid, wb_dest, wb_value);
endinterface

// two combinational operand read ports
interface rf_read_if;
	import scb_pkg::*;
	reg_addr_t addr0;
	data_t data0;
	reg_addr_t addr1;
	data_t data1;
	modport client (output addr0, addr1, input data0, data1);
	modport server (input addr0, addr1, output data0, data1);
endinterface

//--- hdl/instr_intake.sv
`timescale 1ns/1ps
`include "scb_config.svh"

module instr_intake (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           instr_req,
	input  scb_pkg::data_t instr_data,
	output logic           instr_ack,
	dec_if.source          dec
);
	import scb_pkg::*;

	hs_state_e state;
	logic [`SCB_INSTR_W-1:0] hold_q;
	logic full_q;
	opcode_e opc;
	logic known;

	//////////////////////////////////////////////////
	// handshake and holding register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= HS_IDLE;
			full_q <= 1'b0;
		end else begin
			// release on take, or drop a word we cannot execute
			if ((dec.valid && dec.take) || (full_q && !known))
				full_q <= 1'b0;
			case (state)
				HS_IDLE: begin
					if (instr_req && !full_q) begin
						full_q <= 1'b1;
						state <= HS_ACK;
					end
				end
				HS_ACK: state <= HS_WAIT_LOW;
				HS_WAIT_LOW: begin
					if (!instr_req)
						state <= HS_IDLE;
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == HS_IDLE && instr_req && !full_q)
			hold_q <= instr_data;
	end

	assign instr_ack = (state == HS_WAIT_LOW);

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	assign opc = opcode_e'(hold_q[15:11]);

	always_comb begin
		known = 1'b1;
		dec.op = ALU_ADD;
		dec.use_imm = 1'b0;
		case (opc)
			OPC_ADD_IMM: dec.use_imm = 1'b1;
			OPC_ADD_REG: known = 1'b1;
			OPC_SUB_IMM: begin
				dec.op = ALU_SUB;
				dec.use_imm = 1'b1;
			end
			OPC_SUB_REG: dec.op = ALU_SUB;
			default: known = 1'b0;
		endcase
	end

	assign dec.valid = full_q && known;
	assign dec.dest = hold_q[10:8];
	assign dec.src0 = hold_q[7:5];
	assign dec.src1 = hold_q[2:0];
	// sign extended 5-bit immediate
	assign dec.imm = {{(`SCB_DATA_W - 5){hold_q[4]}}, hold_q[4:0]};

endmodule

//--- scoreboard/alu_unit.sv
`timescale 1ns/1ps
`include "scb_config.svh"

module alu_unit (
	input logic clk,
	input logic rst_n,
	fu_if.unit  fu
);
	import scb_pkg::*;

	localparam int STAGES = `SCB_ALU_STAGES;

	logic [STAGES-1:0] vld_q;
	reg_addr_t dest_q [STAGES];
	data_t res_q [STAGES];
	data_t result;

	// wraps modulo 2^16
	always_comb begin
		if (fu.op == ALU_SUB)
			result = fu.a - fu.b;
		else
			result = fu.a + fu.b;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= fu.start;
			for (int i = 1; i < STAGES; i++)
				vld_q[i] <= vld_q[i-1];
		end
	end

	// result and destination ride alongside valid
	always_ff @(posedge clk) begin
		res_q[0] <= result;
		dest_q[0] <= fu.dest;
		for (int i = 1; i < STAGES; i++) begin
			res_q[i] <= res_q[i-1];
			dest_q[i] <= dest_q[i-1];
		end
	end

	assign fu.wb_valid = vld_q[STAGES-1];
	assign fu.wb_dest = dest_q[STAGES-1];
	assign fu.wb_value = res_q[STAGES-1];

endmodule

//--- scoreboard/scoreboard.sv
`timescale 1ns/1ps
`include "scb_config.svh"

module scoreboard (
	input  logic      clk,
	input  logic      rst_n,
	dec_if.sink       dec,
	fu_if.issue       fu0,
	fu_if.issue       fu1,
	rf_read_if.client rf,
	output logic      busy
);
	import scb_pkg::*;

	localparam int NFU = `SCB_NUM_FU;
	localparam int NREG = `SCB_NUM_REGS;

	// unit status table
	logic [NFU-1:0] u_busy;
	logic [NFU-1:0] u_sent;
	logic [NFU-1:0] u_rdy0;
	logic [NFU-1:0] u_rdy1;
	fu_tag_t u_tag0 [NFU];
	fu_tag_t u_tag1 [NFU];
	alu_op_e u_op [NFU];
	reg_addr_t u_dest [NFU];
	data_t u_val0 [NFU];
	data_t u_val1 [NFU];
	// register status table
	logic [NREG-1:0] r_pend;
	fu_tag_t r_tag [NREG];

	logic [NFU-1:0] wb_vld;
	reg_addr_t wb_dest [NFU];
	data_t wb_val [NFU];
	logic [NFU-1:0] start;
	logic issue;
	fu_tag_t issue_fu;
	logic s0_rdy;
	logic s1_rdy;
	fu_tag_t s0_tag;
	fu_tag_t s1_tag;
	data_t s0_val;
	data_t s1_val;

	assign wb_vld = {fu1.wb_valid, fu0.wb_valid};
	assign wb_dest[0] = fu0.wb_dest;
	assign wb_dest[1] = fu1.wb_dest;
	assign wb_val[0] = fu0.wb_value;
	assign wb_val[1] = fu1.wb_value;

	//////////////////////////////////////////////////
	// issue
	//////////////////////////////////////////////////

	// lowest free unit
	always_comb begin
		issue_fu = '0;
		for (int i = NFU - 1; i >= 0; i--) begin
			if (!u_busy[i])
				issue_fu = fu_tag_t'(i);
		end
	end

	// stall on waw or when every unit is taken
	assign issue = dec.valid && !(&u_busy) && !r_pend[dec.dest];
	assign dec.take = issue;
	assign rf.addr0 = dec.src0;
	assign rf.addr1 = dec.src1;

	// operands from the register file or from a writeback in this cycle
	always_comb begin
		s0_tag = r_tag[dec.src0];
		s0_rdy = !r_pend[dec.src0];
		s0_val = rf.data0;
		if (r_pend[dec.src0] && wb_vld[s0_tag] && wb_dest[s0_tag] == dec.src0) begin
			s0_rdy = 1'b1;
			s0_val = wb_val[s0_tag];
		end
		s1_tag = r_tag[dec.src1];
		s1_rdy = !r_pend[dec.src1];
		s1_val = rf.data1;
		if (r_pend[dec.src1] && wb_vld[s1_tag] && wb_dest[s1_tag] == dec.src1) begin
			s1_rdy = 1'b1;
			s1_val = wb_val[s1_tag];
		end
		if (dec.use_imm) begin
			s1_rdy = 1'b1;
			s1_val = dec.imm;
		end
	end

	//////////////////////////////////////////////////
	// status update
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			u_busy <= '0;
			u_sent <= '0;
			u_rdy0 <= '0;
			u_rdy1 <= '0;
			r_pend <= '0;
			for (int u = 0; u < NFU; u++) begin
				u_tag0[u] <= '0;
				u_tag1[u] <= '0;
			end
			for (int r = 0; r < NREG; r++)
				r_tag[r] <= '0;
		end else begin
			for (int u = 0; u < NFU; u++) begin
				if (start[u])
					u_sent[u] <= 1'b1;
				// retire frees the unit and its destination
				if (wb_vld[u]) begin
					u_busy[u] <= 1'b0;
					u_sent[u] <= 1'b0;
					r_pend[wb_dest[u]] <= 1'b0;
				end
				// wake operands waiting on a writing unit
				for (int w = 0; w < NFU; w++) begin
					if (wb_vld[w] && !u_rdy0[u] && u_tag0[u] == fu_tag_t'(w))
						u_rdy0[u] <= 1'b1;
					if (wb_vld[w] && !u_rdy1[u] && u_tag1[u] == fu_tag_t'(w))
						u_rdy1[u] <= 1'b1;
				end
			end
			if (issue) begin
				u_busy[issue_fu] <= 1'b1;
				u_sent[issue_fu] <= 1'b0;
				u_rdy0[issue_fu] <= s0_rdy;
				u_rdy1[issue_fu] <= s1_rdy;
				u_tag0[issue_fu] <= s0_tag;
				u_tag1[issue_fu] <= s1_tag;
				r_pend[dec.dest] <= 1'b1;
				r_tag[dec.dest] <= issue_fu;
			end
		end
	end

	// operand values follow the same wakeup
	always_ff @(posedge clk) begin
		for (int u = 0; u < NFU; u++) begin
			for (int w = 0; w < NFU; w++) begin
				if (wb_vld[w] && !u_rdy0[u] && u_tag0[u] == fu_tag_t'(w))
					u_val0[u] <= wb_val[w];
				if (wb_vld[w] && !u_rdy1[u] && u_tag1[u] == fu_tag_t'(w))
					u_val1[u] <= wb_val[w];
			end
		end
		if (issue) begin
			u_op[issue_fu] <= dec.op;
			u_dest[issue_fu] <= dec.dest;
			u_val0[issue_fu] <= s0_val;
			u_val1[issue_fu] <= s1_val;
		end
	end

	//////////////////////////////////////////////////
	// dispatch
	//////////////////////////////////////////////////

	assign start = u_busy & ~u_sent & u_rdy0 & u_rdy1;

	assign fu0.start = start[0];
	assign fu0.op = u_op[0];
	assign fu0.dest = u_dest[0];
	assign fu0.a = u_val0[0];
	assign fu0.b = u_val1[0];

	assign fu1.start = start[1];
	assign fu1.op = u_op[1];
	assign fu1.dest = u_dest[1];
	assign fu1.a = u_val0[1];
	assign fu1.b = u_val1[1];

	assign busy = |u_busy;

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "scb_config.svh"

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	fu_if.monitor              wb0,
	fu_if.monitor              wb1,
	rf_read_if.server          rf,
	input  scb_pkg::reg_addr_t rd_addr,
	output scb_pkg::data_t     rd_data
);
	import scb_pkg::*;

	data_t regs [`SCB_NUM_REGS];

	//////////////////////////////////////////////////
	// writeback
	//////////////////////////////////////////////////

	// both units may land in one cycle but never on the same register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `SCB_NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			if (wb0.wb_valid)
				regs[wb0.wb_dest] <= wb0.wb_value;
			if (wb1.wb_valid)
				regs[wb1.wb_dest] <= wb1.wb_value;
		end
	end

	//////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////

	// no bypass as the scoreboard forwards writebacks itself
	assign rf.data0 = regs[rf.addr0];
	assign rf.data1 = regs[rf.addr1];

	// external readout
	assign rd_data = regs[rd_addr];

endmodule

//--- hdl/scb_core.sv
`timescale 1ns/1ps

module scb_core (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_req,
	input  scb_pkg::data_t     instr_data,
	output logic               instr_ack,
	input  scb_pkg::reg_addr_t rd_addr,
	output scb_pkg::data_t     rd_data,
	output logic               idle
);

	dec_if dec_bus ();
	fu_if fu0_bus ();
	fu_if fu1_bus ();
	rf_read_if rf_bus ();

	logic sb_busy;

	// input side
	instr_intake i_instr_intake (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr_req  (instr_req),
		.instr_data (instr_data),
		.instr_ack  (instr_ack),
		.dec        (dec_bus)
	);

	//////////////////////////////////////////////////
	// scoreboard and arithmetic units
	//////////////////////////////////////////////////

	scoreboard i_scoreboard (
		.clk   (clk),
		.rst_n (rst_n),
		.dec   (dec_bus),
		.fu0   (fu0_bus),
		.fu1   (fu1_bus),
		.rf    (rf_bus),
		.busy  (sb_busy)
	);

	alu_unit i_alu0 (
		.clk   (clk),
		.rst_n (rst_n),
		.fu    (fu0_bus)
	);

	alu_unit i_alu1 (
		.clk   (clk),
		.rst_n (rst_n),
		.fu    (fu1_bus)
	);

	// output side
	reg_file i_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.wb0     (fu0_bus),
		.wb1     (fu1_bus),
		.rf      (rf_bus),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// nothing in the handshake, the holding register or a unit
	assign idle = !(instr_ack | dec_bus.valid | sb_busy);

endmodule

//--- verification/scb_core_properties.sv
`timescale 1ns/1ps

module scb_core_properties (
	input logic               clk,
	input logic               rst_n,
	input logic               instr_req,
	input logic               instr_ack,
	input logic               dec_valid,
	input logic               dec_take,
	input logic               fu0_start,
	input logic               fu1_start,
	input logic               wb0_valid,
	input logic               wb1_valid,
	input scb_pkg::reg_addr_t wb0_dest,
	input scb_pkg::reg_addr_t wb1_dest
);

	// longest stall of a decoded word before issue
	localparam int TAKE_LIMIT = 32;

	int wait_cnt;
	logic [1:0] in_flight;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= 0;
			in_flight <= '0;
		end else begin
			if (dec_valid && !dec_take)
				wait_cnt <= wait_cnt + 1;
			else
				wait_cnt <= 0;
			if (wb0_valid)
				in_flight[0] <= 1'b0;
			if (fu0_start)
				in_flight[0] <= 1'b1;
			if (wb1_valid)
				in_flight[1] <= 1'b0;
			if (fu1_start)
				in_flight[1] <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// handshake and scoreboard rules
	//////////////////////////////////////////////////

	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(instr_ack) |-> $past(instr_req))
		else $error("instr_ack rose while instr_req was low");

	held_word_taken: assert property (@(posedge clk) disable iff (!rst_n)
		wait_cnt < TAKE_LIMIT)
		else $error("decoded instruction not taken by the scoreboard");

	wb_dest_unique: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb0_valid && wb1_valid && wb0_dest == wb1_dest))
		else $error("two writebacks to one register in the same cycle");

	one_op_fu0: assert property (@(posedge clk) disable iff (!rst_n)
		fu0_start |-> !in_flight[0])
		else $error("unit 0 started again before its writeback");

	one_op_fu1: assert property (@(posedge clk) disable iff (!rst_n)
		fu1_start |-> !in_flight[1])
		else $error("unit 1 started again before its writeback");

endmodule

bind scb_core scb_core_properties i_scb_core_properties (
	.clk       (clk),
	.rst_n     (rst_n),
	.instr_req (instr_req),
	.instr_ack (instr_ack),
	.dec_valid (dec_bus.valid),
	.dec_take  (dec_bus.take),
	.fu0_start (fu0_bus.start),
	.fu1_start (fu1_bus.start),
	.wb0_valid (fu0_bus.wb_valid),
	.wb1_valid (fu1_bus.wb_valid),
	.wb0_dest  (fu0_bus.wb_dest),
	.wb1_dest  (fu1_bus.wb_dest)
);

//--- verification/tb_scb_core.sv
`timescale 1ns/1ps

module tb_scb_core;
	import scb_pkg::*;

	localparam string STIM_FILE = "verification/scb_stim.txt";
	// watchdog budget in clock cycles
	localparam int CYC_PER_INSTR = 40;
	localparam int CYC_PER_CHECK = 4;
	localparam int CYC_BASE = 50;

	logic clk;
	logic rst_n;
	logic instr_req;
	data_t instr_data;
	logic instr_ack;
	reg_addr_t rd_addr;
	data_t rd_data;
	logic idle;

	// one entry per record of the stim file
	logic [7:0] q_kind [$];
	logic [127:0] q_name [$];
	logic [15:0] q_a [$];
	logic [15:0] q_b [$];

	logic stim_ok;
	int n_instr;
	int n_checks;
	int limit_cycles;
	logic [15:0] lfsr;
	logic [127:0] cur_name;
	logic in_test;
	logic settled;
	int test_errs;
	int test_checks;
	int n_tests;
	int n_failed;
	int total_errs;
	int total_checks;

	scb_core i_scb_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr_req  (instr_req),
		.instr_data (instr_data),
		.instr_ack  (instr_ack),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.idle       (idle)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// galois lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	task automatic read_stim();
		int fd;
		int code;
		logic [7:0] kind;
		logic [127:0] name;
		logic [15:0] a;
		logic [15:0] b;
		logic [8*160-1:0] rest;
		fd = $fopen(STIM_FILE, "r");
		stim_ok = (fd != 0);
		if (stim_ok) begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", kind);
				if (code == 1) begin
					if (kind == "#") begin
						code = $fgets(rest, fd);
					end else if (kind == "T") begin
						code = $fscanf(fd, "%s", name);
						q_kind.push_back(kind);
						q_name.push_back(name);
						q_a.push_back(16'h0);
						q_b.push_back(16'h0);
					end else if (kind == "I") begin
						code = $fscanf(fd, "%h", a);
						q_kind.push_back(kind);
						q_name.push_back(name);
						q_a.push_back(a);
						q_b.push_back(16'h0);
						n_instr++;
					end else if (kind == "E") begin
						code = $fscanf(fd, "%d %h", a, b);
						q_kind.push_back(kind);
						q_name.push_back(name);
						q_a.push_back(a);
						q_b.push_back(b);
						n_checks++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// four-phase transfer of one word from a falling edge
	task automatic send_word(input logic [15:0] word);
		instr_data = word;
		instr_req = 1'b1;
		while (!instr_ack)
			@(negedge clk);
		instr_req = 1'b0;
		while (instr_ack)
			@(negedge clk);
	endtask

	// 0 to 7 idle cycles between requests
	task automatic random_gap();
		int gap;
		gap = 0;
		for (int b = 0; b < 3; b++) begin
			lfsr = lfsr_next(lfsr);
			gap = (gap << 1) | int'(lfsr[0]);
		end
		repeat (gap) @(negedge clk);
	endtask

	task automatic wait_idle();
		while (!idle)
			@(negedge clk);
	endtask

	task automatic check_reg(input logic [15:0] r, input logic [15:0] expected);
		rd_addr = r[2:0];
		@(negedge clk);
		test_checks++;
		if (rd_data !== expected) begin
			$display("ERR %0s r%0d expected %h actual %h", cur_name, r, expected, rd_data);
			test_errs++;
		end
	endtask

	task automatic end_test();
		n_tests++;
		if (test_errs == 0) begin
			$display("test %0s: pass, %0d checks", cur_name, test_checks);
		end else begin
			n_failed++;
			$display("test %0s: FAIL, %0d of %0d checks wrong", cur_name, test_errs,
				test_checks);
		end
		total_errs += test_errs;
		total_checks += test_checks;
	endtask

	task automatic run_stim();
		for (int i = 0; i < q_kind.size(); i++) begin
			if (q_kind[i] == "T") begin
				if (in_test)
					end_test();
				in_test = 1'b1;
				settled = 1'b0;
				cur_name = q_name[i];
				test_errs = 0;
				test_checks = 0;
			end else if (q_kind[i] == "I") begin
				send_word(q_a[i]);
				random_gap();
				settled = 1'b0;
			end else begin
				// results only count once all work has retired
				if (!settled) begin
					wait_idle();
					settled = 1'b1;
				end
				check_reg(q_a[i], q_b[i]);
			end
		end
		if (in_test)
			end_test();
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		instr_req = 1'b0;
		instr_data = '0;
		rd_addr = '0;
		lfsr = 16'd10634;
		n_instr = 0;
		n_checks = 0;
		in_test = 1'b0;
		settled = 1'b0;
		n_tests = 0;
		n_failed = 0;
		total_errs = 0;
		total_checks = 0;
		read_stim();
		if (!stim_ok) begin
			$display("stimulus file %0s could not be opened", STIM_FILE);
			$display("Simulation FAILED");
			$finish;
		end else begin
			limit_cycles = CYC_PER_INSTR * n_instr + CYC_PER_CHECK * n_checks + CYC_BASE;
			repeat (2) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			if (idle !== 1'b1) begin
				$display("idle is not high after reset");
				total_errs++;
			end
			run_stim();
			$display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed,
				total_checks, total_errs);
			if (total_errs == 0)
				$display("Simulation PASSED");
			else
				$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limit_cycles);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- verification/scb_stim.txt
# T <test name> | I <instruction word, hex> | E <register> <expected value, hex>
# expected values follow the program order of the I lines
T reset
E 0 0000
E 1 0000
E 2 0000
E 3 0000
E 4 0000
E 5 0000
E 6 0000
E 7 0000
T imm
I 0105
I 021d
I 1330
I 1401
E 1 0005
E 2 fffd
E 3 0015
E 4 ffff
T raw_chain
I 0d23
I 1ea2
I 0fc6
I 1de5
E 5 0020
E 6 001d
E 7 003a
T waw
I 0ae7
I 0942
I 0109
E 1 0009
E 2 0074
T dual_unit
I 0307
I 1402
I fd01
I 0621
I 1f41
I 2003
E 0 0000
E 1 0009
E 2 0074
E 3 0007
E 4 fffe
E 5 0020
E 6 000a
E 7 006b

//--- filelist.f
+incdir+common
common/scb_pkg.sv
common/scb_if.sv
hdl/instr_intake.sv
scoreboard/alu_unit.sv
scoreboard/scoreboard.sv
hdl/reg_file.sv
hdl/scb_core.sv
verification/scb_core_properties.sv
verification/tb_scb_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_scb_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
